/* router_top.f */
src/router_pkg.sv
src/router_fifo.sv
src/router_egress.sv
src/router_parity_check.sv
src/router_ingress.sv
src/router_top.sv
testbench/router_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
TOP       = router_tb
FILELIST  = router_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/router_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module router_tb;

	import router_pkg::*;

	localparam int          CLK_PERIOD   = 20;
	localparam logic [31:0] SEED         = 32'h2667da2f;
	localparam int          RD_EAGER     = 0; // read whenever vld_out is high
	localparam int          RD_STALL     = 1; // random stalls, always under the timeout
	localparam int          RD_OFF       = 2; // never read
	// worst case cycles per test: reset, basic, long stalled, parity, busy port, flush, addr 3
	localparam int          WORST_CYCLES = 20 + 200 + 3000 + 250 + 250 + 200 + 150;
	localparam int          WATCHDOG_NS  = 2 * WORST_CYCLES * CLK_PERIOD;

	logic       clk = 1'b0;
	logic       resetn;
	logic       packet_valid;
	byte_t      datain;
	byte_t      data_out [NUM_PORTS];
	port_mask_t vld;
	logic       err;
	logic       busy;

	int          rd_mode [NUM_PORTS]; // reader behavior per port
	logic        popped [NUM_PORTS];  // a byte left the fifo at the last posedge
	byte_t       exp_q [NUM_PORTS][$];
	logic [31:0] src_seed = SEED;
	logic        busy_seen;
	int          errors = 0;
	int          errors_at_start;
	int          n_tests = 0;
	int          n_ok = 0;
	string       test_name;

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------------------------
	// readers, one per port
	// ----------------------------------------------------------
	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_rd
		logic        enb = 1'b0;
		int          stall = 0;                  // cycles left in a stall
		logic [31:0] seed = SEED ^ 32'(p + 1);

		always @(negedge clk)
		begin
			if (!resetn || rd_mode[p] == RD_OFF)
				enb = 1'b0;
			else if (stall > 0)
			begin
				enb = 1'b0;
				stall--;
			end
			else
			begin
				seed = lcg_step(seed);
				// a new stall only right after a read
				if (rd_mode[p] == RD_STALL && vld[p] && enb && seed[17:16] == 2'b00)
				begin
					stall = int'(seed[28:24]) % 20 + 1; // at most 21 idle cycles
					enb = 1'b0;
				end
				else
					enb = vld[p];
			end
		end

		always @(posedge clk)
			popped[p] <= resetn && enb && vld[p];
	end

	router_top i_dut (
		.clk          (clk),
		.resetn       (resetn),
		.packet_valid (packet_valid),
		.datain       (datain),
		.read_enb_0   (g_rd[0].enb),
		.read_enb_1   (g_rd[1].enb),
		.read_enb_2   (g_rd[2].enb),
		.data_out_0   (data_out[0]),
		.data_out_1   (data_out[1]),
		.data_out_2   (data_out[2]),
		.vld_out_0    (vld[0]),
		.vld_out_1    (vld[1]),
		.vld_out_2    (vld[2]),
		.err          (err),
		.busy         (busy)
	);

	// ----------------------------------------------------------
	// reference model and random numbers
	// ----------------------------------------------------------
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int rand_below(input int n);
		src_seed = lcg_step(src_seed);
		return int'(src_seed[30:16]) % n;
	endfunction

	// xor of header and every payload byte
	function automatic byte_t ref_parity(input byte_t bytes [$]);
		byte_t x;
		x = '0;
		foreach (bytes[i])
			x = x ^ bytes[i];
		return x;
	endfunction

	task automatic check_byte(input int port, input byte_t got, input byte_t expected);
		if (got !== expected)
		begin
			$display("error at %0t ns: port %0d data_out %02h, expected %02h",
				$time, port, got, expected);
			errors++;
		end
	endtask

	task automatic check_err(input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("error at %0t ns: err is %b, expected %b", $time, got, expected);
			errors++;
		end
	endtask

	// compare every popped byte, data_out settled since the posedge
	always @(negedge clk)
	begin
		for (int p = 0; p < NUM_PORTS; p++)
			if (popped[p] === 1'b1)
			begin
				if (exp_q[p].size() == 0)
				begin
					$display("port %0d put out a byte nobody sent to it at %0t ns", p, $time);
					errors++;
				end
				else
					check_byte(p, data_out[p], exp_q[p].pop_front());
			end
	end

	// ----------------------------------------------------------
	// source
	// ----------------------------------------------------------
	task automatic send_packet(input port_addr_t addr, input int len,
		input logic bad_parity, input logic deliver);
		byte_t pkt [$];
		byte_t par;
		pkt.push_back({len[5:0], addr});
		for (int i = 0; i < len; i++)
		begin
			src_seed = lcg_step(src_seed);
			pkt.push_back(src_seed[23:16]);
		end
		par = ref_parity(pkt);
		pkt.push_back(bad_parity ? ~par : par);
		for (int i = 0; i < pkt.size(); i++)
		begin
			@(negedge clk);
			packet_valid = (i < pkt.size() - 1); // low for the parity byte
			datain = pkt[i];
			while (busy)
			begin
				if (i > 1)
					busy_seen = 1'b1; // past the header load only a full fifo holds us
				@(negedge clk);
			end
			if (deliver)
				exp_q[addr].push_back(pkt[i]); // taken at the coming posedge
		end
		// err is settled once the controller is back to idle
		@(negedge clk);
		while (busy)
			@(negedge clk);
		check_err(err, bad_parity);
	endtask

	task automatic send_bad_address();
		@(negedge clk);
		packet_valid = 1'b1;
		datain = {6'd5, 2'b11}; // no port 3
		while (busy)
			@(negedge clk);
		@(negedge clk);
		packet_valid = 1'b0;
	endtask

	// ----------------------------------------------------------
	// test bookkeeping
	// ----------------------------------------------------------
	task automatic start_test(input string name);
		@(posedge clk);
		for (int p = 0; p < NUM_PORTS; p++)
			rd_mode[p] = RD_EAGER;
		test_name = name;
		errors_at_start = errors;
	endtask

	// all ports empty and controller idle, then leftovers are missing bytes
	task automatic wait_drained();
		do
			@(negedge clk);
		while (vld != '0 || busy);
		@(negedge clk);
		for (int p = 0; p < NUM_PORTS; p++)
			if (exp_q[p].size() != 0)
			begin
				$display("port %0d never delivered %0d expected bytes", p, exp_q[p].size());
				errors++;
				exp_q[p].delete();
			end
	endtask

	task automatic finish_test();
		int n;
		wait_drained();
		n = errors - errors_at_start;
		n_tests++;
		if (n == 0)
		begin
			n_ok++;
			$display("%s: ok", test_name);
		end
		else
			$display("%s: %0d errors", test_name, n);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog ran out at %0t ns, a test never finished", $time);
		$display("test failed");
		$finish;
	end

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial
	begin
		int p;
		$timeformat(-9, 0, "", 0);
		resetn = 1'b0;
		packet_valid = 1'b0;
		datain = '0;
		repeat (4) @(negedge clk);
		resetn = 1'b1;

		start_test("reset state");
		@(negedge clk);
		if (busy || vld != '0)
		begin
			$display("busy or a vld_out is high right after reset");
			errors++;
		end
		check_err(err, 1'b0);
		for (int q = 0; q < NUM_PORTS; q++)
			check_byte(q, data_out[q], 8'h00);
		finish_test();

		start_test("basic delivery");
		for (int q = 0; q < NUM_PORTS; q++)
			send_packet(port_addr_t'(q), rand_below(20) + 1, 1'b0, 1'b1);
		finish_test();

		start_test("long packet, stalled reader");
		p = rand_below(NUM_PORTS);
		rd_mode[p] = RD_STALL;
		busy_seen = 1'b0;
		send_packet(port_addr_t'(p), 63, 1'b0, 1'b1);
		if (!busy_seen)
		begin
			$display("busy never rose during the 63 byte packet");
			errors++;
		end
		finish_test();

		start_test("parity error");
		p = rand_below(NUM_PORTS);
		send_packet(port_addr_t'(p), rand_below(20) + 1, 1'b1, 1'b1);
		send_packet(port_addr_t'(p), rand_below(20) + 1, 1'b0, 1'b1);
		finish_test();

		start_test("busy destination");
		p = rand_below(NUM_PORTS);
		rd_mode[p] = RD_OFF;
		fork
			begin
				send_packet(port_addr_t'(p), 4, 1'b0, 1'b1);
				send_packet(port_addr_t'(p), 4, 1'b0, 1'b1);
			end
			begin
				repeat (20) @(negedge clk); // well inside the timeout
				if (!busy)
				begin
					$display("second packet to port %0d was not held", p);
					errors++;
				end
				@(posedge clk);
				rd_mode[p] = RD_EAGER;
			end
		join
		finish_test();

		start_test("timeout flush");
		p = rand_below(NUM_PORTS);
		rd_mode[p] = RD_OFF;
		send_packet(port_addr_t'(p), 3, 1'b0, 1'b0); // flushed, never delivered
		repeat (40) @(negedge clk);
		if (vld[p])
		begin
			$display("port %0d still holds data 40 cycles after its packet", p);
			errors++;
		end
		@(posedge clk);
		rd_mode[p] = RD_EAGER;
		send_packet(port_addr_t'(p), rand_below(20) + 1, 1'b0, 1'b1);
		finish_test();

		start_test("invalid address");
		send_bad_address();
		repeat (10)
		begin
			@(negedge clk);
			if (vld != '0)
			begin
				$display("a port went valid after a header with address 3");
				errors++;
			end
		end
		send_packet(port_addr_t'(rand_below(NUM_PORTS)), rand_below(20) + 1, 1'b0, 1'b1);
		finish_test();

		$display("%0d tests, %0d ok, %0d with errors, %0d errors in all",
			n_tests, n_ok, n_tests - n_ok, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src/router_top.sv */
`timescale 1ns/10ps
`default_nettype none

module router_top (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire                    packet_valid,
	input  wire router_pkg::byte_t datain,
	input  wire                    read_enb_0,
	input  wire                    read_enb_1,
	input  wire                    read_enb_2,
	output wire router_pkg::byte_t data_out_0,
	output wire router_pkg::byte_t data_out_1,
	output wire router_pkg::byte_t data_out_2,
	output wire                    vld_out_0,
	output wire                    vld_out_1,
	output wire                    vld_out_2,
	output wire                    err,
	output wire                    busy
);

	import router_pkg::*;

	// ingress write bus, shared by all ports
	byte_t      wr_data;
	port_mask_t wr_enb;
	logic       wr_any;
	logic       wr_first;
	logic       wr_last;

	// per port status gathered into masks
	port_mask_t full_mask;
	port_mask_t empty_mask;
	port_mask_t flush_mask;
	port_mask_t vld_mask;
	port_mask_t read_mask;
	byte_t      port_data [NUM_PORTS];

	assign read_mask  = {read_enb_2, read_enb_1, read_enb_0};
	assign empty_mask = ~vld_mask; // vld_out is plain not-empty

	// ----------------------------------------------------------
	// input side
	// ----------------------------------------------------------
	router_ingress u_ingress (
		.clk          (clk),
		.resetn       (resetn),
		.packet_valid (packet_valid),
		.datain       (datain),
		.dest_full    (full_mask),
		.dest_empty   (empty_mask),
		.flush        (flush_mask),
		.busy         (busy),
		.wr_data      (wr_data),
		.wr_enb       (wr_enb),
		.wr_any       (wr_any),
		.wr_first     (wr_first),
		.wr_last      (wr_last)
	);

	// parity watches what actually lands in a fifo
	router_parity_check u_parity (
		.clk      (clk),
		.resetn   (resetn),
		.wr_data  (wr_data),
		.wr_any   (wr_any),
		.wr_first (wr_first),
		.wr_last  (wr_last),
		.err      (err)
	);

	// ----------------------------------------------------------
	// output side, one egress per port
	// ----------------------------------------------------------
	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		router_egress u_egress (
			.clk      (clk),
			.resetn   (resetn),
			.wr_en    (wr_enb[p]),
			.wr_data  (wr_data),
			.read_enb (read_mask[p]),
			.data_out (port_data[p]),
			.vld_out  (vld_mask[p]),
			.full     (full_mask[p]),
			.flush    (flush_mask[p])
		);
	end

	assign data_out_0 = port_data[0];
	assign data_out_1 = port_data[1];
	assign data_out_2 = port_data[2];
	assign vld_out_0  = vld_mask[0];
	assign vld_out_1  = vld_mask[1];
	assign vld_out_2  = vld_mask[2];

endmodule

`default_nettype wire

/* src/router_ingress.sv */
`timescale 1ns/10ps
`default_nettype none

module router_ingress (
	input  wire                         clk,
	input  wire                         resetn,
	input  wire                         packet_valid,
	input  wire router_pkg::byte_t      datain,
	input  wire router_pkg::port_mask_t dest_full,
	input  wire router_pkg::port_mask_t dest_empty,
	input  wire router_pkg::port_mask_t flush,
	output logic                        busy,
	output router_pkg::byte_t           wr_data,
	output router_pkg::port_mask_t      wr_enb,
	output logic                        wr_any,
	output logic                        wr_first,
	output logic                        wr_last
);

	import router_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	port_addr_t dest_q;        // destination of the current packet
	byte_t      header_q;      // header waits here one cycle
	byte_t      held_q;        // byte taken while the fifo was full
	logic       held_parity_q; // that byte was the parity byte

	port_addr_t hdr_addr;
	port_mask_t hdr_mask;      // zero for address 3
	port_mask_t dest_mask;
	logic       hdr_take;
	logic       d_full;
	logic       d_empty;
	logic       d_flush;
	logic       abortable;
	logic       wr_go;

	// ----------------------------------------------------------
	// port decode
	// ----------------------------------------------------------
	assign hdr_addr  = datain[1:0];
	assign hdr_mask  = port_mask_t'(1) << hdr_addr; // shifts out for port 3
	assign dest_mask = port_mask_t'(1) << dest_q;

	assign d_full  = |(dest_full & dest_mask);
	assign d_empty = |(dest_empty & dest_mask);
	assign d_flush = |(flush & dest_mask);

	// header accepted only for a real port
	assign hdr_take = (state == decode_address) && packet_valid && (|hdr_mask);

	// a flush of the destination kills the packet in these states
	// wait_till_empty just sees the port drain instead
	assign abortable = (state != decode_address) && (state != wait_till_empty);

	// ----------------------------------------------------------
	// state machine
	// ----------------------------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			decode_address:
				if (hdr_take)
					state_nxt = (|(dest_empty & hdr_mask)) ? load_first_data : wait_till_empty;
			wait_till_empty:
				if (d_empty)
					state_nxt = load_first_data;
			load_first_data:
				state_nxt = load_data;
			load_data:
				if (d_full)
					state_nxt = fifo_full_state; // byte goes to held_q
				else if (!packet_valid)
					state_nxt = load_parity;     // parity written this cycle
			fifo_full_state:
				if (!d_full)
					state_nxt = load_after_full;
			load_after_full:
				state_nxt = held_parity_q ? load_parity : load_data;
			load_parity:
				state_nxt = check_parity_error;
			check_parity_error:
				state_nxt = decode_address;
			default:
				state_nxt = decode_address;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
			state <= decode_address;
		else if (d_flush && abortable)
			state <= decode_address; // rest of the packet is lost
		else
			state <= state_nxt;
	end

	// destination and held parity flag
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			dest_q        <= '0;
			held_parity_q <= 1'b0;
		end
		else
		begin
			if (hdr_take)
				dest_q <= hdr_addr;
			if (state == load_data && d_full)
				held_parity_q <= !packet_valid;
		end
	end

	// byte holding registers
	always_ff @(posedge clk)
	begin
		if (hdr_take)
			header_q <= datain;
		if (state == load_data && d_full)
			held_q <= datain;
	end

	// ----------------------------------------------------------
	// write steering
	// ----------------------------------------------------------
	always_comb
	begin
		wr_go    = 1'b0;
		wr_data  = datain;
		wr_first = 1'b0;
		wr_last  = 1'b0;
		case (state)
			load_first_data:
			begin
				wr_go    = 1'b1;
				wr_data  = header_q;
				wr_first = 1'b1;
			end
			load_data:
			begin
				wr_go   = !d_full;                  // straight from datain
				wr_last = !d_full && !packet_valid;
			end
			load_after_full:
			begin
				wr_go   = 1'b1;
				wr_data = held_q;
				wr_last = held_parity_q;
			end
			default:
				wr_go = 1'b0;
		endcase
		// nothing lands in a port that is being flushed
		if (d_flush)
		begin
			wr_go    = 1'b0;
			wr_first = 1'b0;
			wr_last  = 1'b0;
		end
	end

	assign wr_enb = wr_go ? dest_mask : '0;
	assign wr_any = wr_go;

	// source holds its byte in every state that takes no input
	assign busy = state inside {wait_till_empty, load_first_data, load_parity,
		fifo_full_state, load_after_full, check_parity_error};

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	// every write lands in exactly one real port, never in address 3
	a_wr_onehot: assert property (@(posedge clk) disable iff (!resetn)
		wr_any |-> $onehot(wr_enb));

	// fifo full flags come back from the egress side
	a_wr_not_full: assert property (@(posedge clk) disable iff (!resetn)
		(wr_enb & dest_full) == '0);

endmodule

`default_nettype wire

/* src/router_parity_check.sv */
`timescale 1ns/10ps
`default_nettype none

module router_parity_check (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire router_pkg::byte_t wr_data,
	input  wire                    wr_any,
	input  wire                    wr_first,
	input  wire                    wr_last,
	output logic                   err
);

	import router_pkg::*;

	byte_t acc; // xor of header and payload so far

	// ----------------------------------------------------------
	// running xor
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (wr_any)
		begin
			if (wr_first)
				acc <= wr_data;       // header restarts it
			else if (!wr_last)
				acc <= acc ^ wr_data; // payload folds in
		end
	end

	// compare against the parity byte as it is written
	always_ff @(posedge clk)
	begin
		if (!resetn)
			err <= 1'b0;
		else if (wr_any && wr_last)
			err <= (acc != wr_data); // holds until next parity write
	end

endmodule

`default_nettype wire

/* src/router_egress.sv */
`timescale 1ns/10ps
`default_nettype none

module router_egress (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire                    wr_en,
	input  wire router_pkg::byte_t wr_data,
	input  wire                    read_enb,
	output router_pkg::byte_t      data_out,
	output logic                   vld_out,
	output logic                   full,
	output logic                   flush
);

	import router_pkg::*;

	timeout_cnt_t idle_cnt; // unread cycles with data waiting
	logic         empty;
	logic         rd_en;
	logic         idle;

	router_fifo u_fifo (
		.clk     (clk),
		.resetn  (resetn),
		.flush   (flush),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_data (data_out),
		.full    (full),
		.empty   (empty)
	);

	assign vld_out = !empty;
	assign rd_en   = read_enb && vld_out; // pops only with data present

	// ----------------------------------------------------------
	// unread timeout
	// ----------------------------------------------------------
	assign idle = vld_out && !read_enb && !flush;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			idle_cnt <= '0;
			flush    <= 1'b0;
		end
		else
		begin
			flush <= 1'b0; // single cycle pulse
			if (!idle)
				idle_cnt <= '0;
			else if (idle_cnt == timeout_cnt_t'(TIMEOUT_CYCLES - 1))
			begin
				idle_cnt <= '0;
				flush    <= 1'b1;
			end
			else
				idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// flush only with data, port empty right after
	a_flush_vld: assert property (@(posedge clk) disable iff (!resetn)
		flush |-> vld_out ##1 !vld_out);

endmodule

`default_nettype wire

/* src/router_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module router_fifo (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire                    flush,
	input  wire                    wr_en,
	input  wire router_pkg::byte_t wr_data,
	input  wire                    rd_en,
	output router_pkg::byte_t      rd_data,
	output logic                   full,
	output logic                   empty
);

	import router_pkg::*;

	byte_t     mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fifo_cnt_t count;  // occupancy
	logic      do_wr;
	logic      do_rd;

	assign full  = (count == fifo_cnt_t'(FIFO_DEPTH));
	assign empty = (count == '0);

	// flush beats both read and write
	assign do_wr = wr_en && !full && !flush;
	assign do_rd = rd_en && !empty && !flush;

	// ----------------------------------------------------------
	// storage
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// pointers wrap on their own at 16
	always_ff @(posedge clk)
	begin
		if (!resetn || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// registered read port, holds between pops
	always_ff @(posedge clk)
	begin
		if (!resetn)
			rd_data <= '0;
		else if (do_rd)
			rd_data <= mem[rd_ptr];
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
		wr_en |-> !full);

	a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
		rd_en |-> !empty);

endmodule

`default_nettype wire

/* src/router_pkg.sv */
`default_nettype none

package router_pkg;

	// ----------------------------------------------------------
	// router sizes
	// ----------------------------------------------------------
	localparam int NUM_PORTS      = 3;  // output ports 0..2
	localparam int FIFO_DEPTH     = 16; // bytes per port fifo
	localparam int TIMEOUT_CYCLES = 30; // unread cycles before a port flush

	// ----------------------------------------------------------
	// vector types
	// ----------------------------------------------------------
	typedef logic [7:0]           byte_t;        // one packet byte
	typedef logic [1:0]           port_addr_t;   // header bits 1:0
	typedef logic [NUM_PORTS-1:0] port_mask_t;   // one bit per port
	typedef logic [3:0]           fifo_ptr_t;    // wraps at 16
	typedef logic [4:0]           fifo_cnt_t;    // 0..16
	typedef logic [4:0]           timeout_cnt_t; // counts up to 29

	// packet controller states
	typedef enum logic [2:0] {
		decode_address,     // idle, header taken here
		wait_till_empty,    // destination still holds an older packet
		load_first_data,    // held header goes into the fifo
		load_data,          // payload and parity taken here
		load_parity,        // parity written, err settles
		fifo_full_state,    // destination full, byte held
		load_after_full,    // held byte written
		check_parity_error  // last busy cycle of the packet
	} ctrl_state_e;

endpackage

`default_nettype wire
